//--- project.f
verilog/memSysPkg.sv
verilog/cacheControl.sv
verilog/instrCache.sv
verilog/dataCache.sv
verilog/busArbiter.sv
verilog/mainMemory.sv
verilog/memSysTop.sv
verif/clockGen.sv
verif/memSysTb.sv

//--- run.sh
#!/bin/sh
# Build and run the memory system testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot enter project root"
  exit 1
fi

verilator --binary --timing --assert --top-module memSysTb -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/VmemSysTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1

//--- verif/memSysTb.sv
// Memory system testbench; reads only addresses it has written first in the unreset main memory
`timescale 1ns/100ps

module memSysTb;

  localparam int QUARTER        = 25;
  // Roughly 300 accesses of up to 10 cycles each plus margin
  localparam int TIMEOUT_CYCLES = 4000;
  localparam int LINES          = memSysPkg::CACHE_LINES;

  logic               clk;
  logic               rstN;
  logic               ctlWrite;
  logic [1:0]         ctlAddr;
  logic [31:0]        ctlWdata;
  logic [31:0]        ctlRdata;
  memSysPkg::coreReqS fetchReq;
  memSysPkg::coreRspS fetchRsp;
  memSysPkg::coreReqS dataReq;
  memSysPkg::coreRspS dataRsp;

  // Reference memory and fetch cache model
  logic [31:0] refMem [memSysPkg::MEM_WORDS];
  logic        iValidM [LINES];
  logic [23:0] iTagM [LINES];
  logic [31:0] iWordM [LINES];
  logic        iEnableM;
  logic        dEnableM;

  // Completed reads waiting for comparison
  string       nameQ [$];
  logic [31:0] expQ [$];
  logic [31:0] actQ [$];
  time         timeQ [$];

  int checkCount = 0;
  int errorCount = 0;
  int cycleCount = 0;
  int seed;

  clockGen clkGen (
    .clk (clk ),
    .rstN(rstN)
  );

  memSysTop dut (
    .clk     (clk     ),
    .rstN    (rstN    ),
    .ctlWrite(ctlWrite),
    .ctlAddr (ctlAddr ),
    .ctlWdata(ctlWdata),
    .ctlRdata(ctlRdata),
    .fetchReq(fetchReq),
    .fetchRsp(fetchRsp),
    .dataReq (dataReq ),
    .dataRsp (dataRsp )
  );

  // Byte n of newWord replaces byte n of oldWord when mask bit n is set
  function automatic logic [31:0] applyMask(input logic [31:0] oldWord,
                                            input logic [31:0] newWord,
                                            input logic [3:0]  mask);
    logic [31:0] bits;
    bits = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
    return (oldWord & ~bits) | (newWord & bits);
  endfunction

  function automatic logic fetchHit(input memSysPkg::memAddrU a);
    return iEnableM && iValidM[a.f.index] && iTagM[a.f.index] == a.f.tag;
  endfunction

  // Held line wins over memory even when stale
  function automatic logic [31:0] expectFetch(input memSysPkg::memAddrU a);
    if (fetchHit(a))
      return iWordM[a.f.index];
    return refMem[a.raw[11:2]];
  endfunction

  function automatic void fillFetchModel(input memSysPkg::memAddrU a);
    if (iEnableM && !fetchHit(a))
    begin
      iValidM[a.f.index] = 1'b1;
      iTagM[a.f.index]   = a.f.tag;
      iWordM[a.f.index]  = refMem[a.raw[11:2]];
    end
  endfunction

  function automatic memSysPkg::coreReqS buildReq(input logic [31:0] addr, input logic rd,
                                                  input logic wr, input logic [31:0] wdata,
                                                  input logic [3:0] mask);
    memSysPkg::coreReqS req;
    req.addr.raw = addr;
    req.wdata    = wdata;
    req.byteMask = mask;
    req.read     = rd;
    req.write    = wr;
    return req;
  endfunction

  function automatic logic [31:0] lineAddr(input int tag, input int index);
    return {tag[23:0], index[5:0], 2'b00};
  endfunction

  // Pattern spread over every address bit
  function automatic logic [31:0] fillPattern(input logic [31:0] addr);
    return (addr * 32'h9E3779B1) ^ 32'hC3A50F96;
  endfunction

  function automatic void recordCheck(input string name, input logic [31:0] expVal,
                                      input logic [31:0] actVal);
    nameQ.push_back(name);
    expQ.push_back(expVal);
    actQ.push_back(actVal);
    timeQ.push_back($time);
  endfunction

  // Stall and rdata settle a quarter cycle after the drive edge
  task automatic waitDone(input logic isFetch);
    #QUARTER;
    while (isFetch ? fetchRsp.stall : dataRsp.stall)
    begin
      @(negedge clk);
      #QUARTER;
    end
  endtask

  // Access tasks are entered and left on a falling edge
  task automatic fetchWord(input logic [31:0] addr);
    memSysPkg::memAddrU a;
    logic [31:0]        expWord;
    a.raw    = addr;
    expWord  = expectFetch(a);
    fetchReq = buildReq(addr, 1'b1, 1'b0, 32'd0, 4'hF);
    waitDone(1'b1);
    recordCheck("fetchRsp.rdata", expWord, fetchRsp.rdata);
    fillFetchModel(a);
    @(negedge clk);
    fetchReq = '0;
  endtask

  task automatic dataRead(input logic [31:0] addr);
    logic [31:0] expWord;
    // Data port sees memory order through the write-through cache
    expWord = refMem[addr[11:2]];
    dataReq = buildReq(addr, 1'b1, 1'b0, 32'd0, 4'hF);
    waitDone(1'b0);
    recordCheck("dataRsp.rdata", expWord, dataRsp.rdata);
    @(negedge clk);
    dataReq = '0;
  endtask

  task automatic dataWrite(input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] mask);
    dataReq = buildReq(addr, 1'b0, 1'b1, wdata, mask);
    waitDone(1'b0);
    @(negedge clk);
    refMem[addr[11:2]] = applyMask(refMem[addr[11:2]], wdata, mask);
    dataReq = '0;
  endtask

  // One-cycle write and an idle cycle so strobes never merge
  task automatic ctlWriteReg(input logic [1:0] addr, input logic [31:0] wdata);
    ctlWrite = 1'b1;
    ctlAddr  = addr;
    ctlWdata = wdata;
    @(negedge clk);
    ctlWrite = 1'b0;
    if (addr == memSysPkg::CTL_REG)
    begin
      iEnableM = wdata[0];
      dEnableM = wdata[1];
    end
    else if (addr == memSysPkg::CTL_INV_I)
    begin
      for (int l = 0; l < LINES; l++)
        iValidM[l] = 1'b0;
    end
    @(negedge clk);
  endtask

  task automatic ctlReadReg(input logic [1:0] addr);
    logic [31:0] expWord;
    expWord = (addr == memSysPkg::CTL_REG) ? {30'd0, dEnableM, iEnableM} : 32'd0;
    ctlAddr = addr;
    #QUARTER;
    recordCheck("ctlRdata", expWord, ctlRdata);
    @(negedge clk);
  endtask

  // Comparison of completed reads
  always @(negedge clk)
  begin : compareResults
    string       name;
    logic [31:0] expVal;
    logic [31:0] actVal;
    time         t;
    while (expQ.size() > 0)
    begin
      name   = nameQ.pop_front();
      expVal = expQ.pop_front();
      actVal = actQ.pop_front();
      t      = timeQ.pop_front();
      checkCount++;
      assert (actVal === expVal)
      else
      begin
        errorCount++;
        $display("error: time %0t, %s expected %h, got %h", t, name, expVal, actVal);
      end
    end
  end

  // Hang guard
  always @(posedge clk)
  begin
    cycleCount++;
    if (cycleCount >= TIMEOUT_CYCLES)
    begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial
  begin
    logic [31:0] addr;
    logic [31:0] r;
    logic [31:0] oldWord;
    seed     = 74210;
    ctlWrite = 1'b0;
    ctlAddr  = 2'd0;
    ctlWdata = 32'd0;
    fetchReq = '0;
    dataReq  = '0;
    iEnableM = 1'b0;
    dEnableM = 1'b0;
    for (int l = 0; l < LINES; l++)
      iValidM[l] = 1'b0;
    wait (rstN);
    @(negedge clk);

    // Caches off over 4 tags by 16 indexes
    for (int i = 0; i < 64; i++)
      dataWrite(lineAddr(i / 16, i % 16), fillPattern(lineAddr(i / 16, i % 16)), 4'hF);
    for (int i = 0; i < 64; i++)
      dataRead(lineAddr(i / 16, i % 16));
    for (int i = 0; i < 64; i++)
      fetchWord(lineAddr(i / 16, i % 16));

    // Random masked mix with conflicting tags in the data cache
    ctlWriteReg(memSysPkg::CTL_REG, 32'd2);
    ctlReadReg(memSysPkg::CTL_REG);
    for (int n = 0; n < 80; n++)
    begin
      r    = $random(seed);
      addr = lineAddr(int'(r[1:0]), int'(r[5:2]));
      if (r[6])
        dataWrite(addr, $random(seed), r[11:8]);
      else
        dataRead(addr);
    end

    // Fetch cache fill then hit
    ctlWriteReg(memSysPkg::CTL_REG, 32'd3);
    ctlReadReg(memSysPkg::CTL_REG);
    for (int i = 0; i < 8; i++)
      fetchWord(lineAddr(0, i));
    for (int i = 0; i < 8; i++)
      fetchWord(lineAddr(0, i));
    // Without snooping the fetch keeps the old word until CTL_INV_I
    addr    = lineAddr(0, 2);
    oldWord = refMem[addr[11:2]];
    dataWrite(addr, ~oldWord, 4'hF);
    fetchWord(addr);
    dataRead(addr);
    ctlWriteReg(memSysPkg::CTL_INV_I, 32'd0);
    fetchWord(addr);

    // Merge on write hit and data invalidate
    addr = lineAddr(1, 3);
    dataRead(addr);
    dataWrite(addr, 32'h5AA5C33C, 4'b0101);
    dataRead(addr);
    ctlWriteReg(memSysPkg::CTL_INV_D, 32'd0);
    dataRead(addr);
    dataRead(addr);

    // Both ports miss at once
    ctlWriteReg(memSysPkg::CTL_INV_I, 32'd0);
    ctlWriteReg(memSysPkg::CTL_INV_D, 32'd0);
    for (int k = 0; k < 16; k++)
    begin
      fork
        fetchWord(lineAddr(k % 4, k));
        begin
          if (k % 2 == 1)
            dataWrite(lineAddr((k + 1) % 4, 15 - k), fillPattern(lineAddr(k, k)), 4'hF);
          else
            dataRead(lineAddr((k + 1) % 4, 15 - k));
        end
      join
    end

    // Enable bits read back
    ctlWriteReg(memSysPkg::CTL_REG, 32'd1);
    ctlReadReg(memSysPkg::CTL_REG);
    ctlReadReg(memSysPkg::CTL_INV_I);
    ctlWriteReg(memSysPkg::CTL_REG, 32'd3);
    ctlReadReg(memSysPkg::CTL_REG);

    // Let the comparison drain
    repeat (2) @(posedge clk);
    assert (expQ.size() == 0)
    else
    begin
      errorCount++;
      $display("reads were left uncompared at the end of the run");
    end
    $display("checks %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0 && checkCount > 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

//--- verif/clockGen.sv
// Testbench clock of 100 ns period; rstN low for two rising edges, released on a falling edge
`timescale 1ns/100ps

module clockGen (
  output logic clk,
  output logic rstN
);

  localparam int HALF_PERIOD = 50;

  // Free-running clock
  initial
  begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Reset over the first two rising edges
  initial
  begin
    rstN = 1'b0;
    repeat (2) @(posedge clk);
    // Release away from the sampling edge
    @(negedge clk);
    rstN = 1'b1;
  end

endmodule

//--- verilog/memSysTop.sv
// Memory side top; fetch and data ports stall for variable latency, caches start disabled
`timescale 1ns/100ps

module memSysTop (
  input  logic               clk,
  input  logic               rstN,
  input  logic               ctlWrite,
  input  logic [1:0]         ctlAddr,
  input  logic [31:0]        ctlWdata,
  output logic [31:0]        ctlRdata,
  input  memSysPkg::coreReqS fetchReq,
  output memSysPkg::coreRspS fetchRsp,
  input  memSysPkg::coreReqS dataReq,
  output memSysPkg::coreRspS dataRsp
);

  memSysPkg::cacheCtlS cacheCtl;
  // Miss streams into the arbiter
  memSysPkg::busReqS   fetchBusReq;
  memSysPkg::busRspS   fetchBusRsp;
  memSysPkg::busReqS   dataBusReq;
  memSysPkg::busRspS   dataBusRsp;
  // Arbitrated bus to memory
  memSysPkg::busReqS   memReq;
  memSysPkg::busRspS   memRsp;

  cacheControl ctl (
    .clk     (clk     ),
    .rstN    (rstN    ),
    .ctlWrite(ctlWrite),
    .ctlAddr (ctlAddr ),
    .ctlWdata(ctlWdata),
    .ctlRdata(ctlRdata),
    .cacheCtl(cacheCtl)
  );

  instrCache iCache (
    .clk     (clk        ),
    .rstN    (rstN       ),
    .cacheCtl(cacheCtl   ),
    .fetchReq(fetchReq   ),
    .fetchRsp(fetchRsp   ),
    .busReq  (fetchBusReq),
    .busRsp  (fetchBusRsp)
  );

  dataCache dCache (
    .clk     (clk       ),
    .rstN    (rstN      ),
    .cacheCtl(cacheCtl  ),
    .dataReq (dataReq   ),
    .dataRsp (dataRsp   ),
    .busReq  (dataBusReq),
    .busRsp  (dataBusRsp)
  );

  busArbiter arb (
    .clk        (clk        ),
    .rstN       (rstN       ),
    .dataBusReq (dataBusReq ),
    .dataBusRsp (dataBusRsp ),
    .fetchBusReq(fetchBusReq),
    .fetchBusRsp(fetchBusRsp),
    .memReq     (memReq     ),
    .memRsp     (memRsp     )
  );

  mainMemory mem (
    .clk   (clk   ),
    .rstN  (rstN  ),
    .memReq(memReq),
    .memRsp(memRsp)
  );

endmodule

//--- verilog/mainMemory.sv
// Word memory of MEM_WORDS words, ready after MEM_WAIT wait cycles; contents are not reset
`timescale 1ns/100ps

module mainMemory (
  input  logic              clk,
  input  logic              rstN,
  input  memSysPkg::busReqS memReq,
  output memSysPkg::busRspS memRsp
);

  logic [31:0]                   memQ [memSysPkg::MEM_WORDS];
  logic [memSysPkg::WAIT_W-1:0]  waitQ;
  logic [memSysPkg::WORD_W-1:0]  wordIdx;
  logic                          ready;

  // Byte address to word index
  assign wordIdx = memReq.addr.raw[memSysPkg::WORD_W+1:2];
  assign ready   = memReq.valid && waitQ == memSysPkg::WAIT_W'(memSysPkg::MEM_WAIT);

  // Wait counter restarts after every ready
  always_ff @(posedge clk)
  begin
    if (!rstN)
      waitQ <= '0;
    else if (!memReq.valid || ready)
      waitQ <= '0;
    else
      waitQ <= waitQ + 1'b1;
  end

  // Masked bytes land at ready
  always_ff @(posedge clk)
  begin
    if (ready && memReq.write)
      memQ[wordIdx] <= memSysPkg::mergeBytes(memQ[wordIdx], memReq.wdata, memReq.byteMask);
  end

  assign memRsp.ready = ready;
  // Asynchronous read valid with ready
  assign memRsp.rdata = memQ[wordIdx];

  // No address aliasing above 4 KB
  addrRangeA: assert property (@(posedge clk) disable iff (!rstN)
    memReq.valid |-> memReq.addr.raw[31:2] < memSysPkg::MEM_WORDS)
    else $error("memory address beyond MEM_WORDS");

endmodule

//--- verilog/busArbiter.sv
// Fixed-priority bus arbiter, data over fetch; one open transfer at a time
`timescale 1ns/100ps

module busArbiter (
  input  logic              clk,
  input  logic              rstN,
  input  memSysPkg::busReqS dataBusReq,
  output memSysPkg::busRspS dataBusRsp,
  input  memSysPkg::busReqS fetchBusReq,
  output memSysPkg::busRspS fetchBusRsp,
  output memSysPkg::busReqS memReq,
  input  memSysPkg::busRspS memRsp
);

  logic busyQ;
  logic ownerDataQ;
  logic grantData;

  // Owner locked once a request is accepted and otherwise data wins when valid
  assign grantData = busyQ ? ownerDataQ : dataBusReq.valid;
  assign memReq    = grantData ? dataBusReq : fetchBusReq;

  // Read data shared and ready only to the granted master
  always_comb
  begin
    dataBusRsp.rdata  = memRsp.rdata;
    dataBusRsp.ready  = memRsp.ready && grantData;
    fetchBusRsp.rdata = memRsp.rdata;
    fetchBusRsp.ready = memRsp.ready && !grantData;
  end

  // Grant register open from acceptance to ready
  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      busyQ      <= 1'b0;
      ownerDataQ <= 1'b0;
    end
    else if (memRsp.ready)
      busyQ <= 1'b0;
    else if (!busyQ && memReq.valid)
    begin
      busyQ      <= 1'b1;
      ownerDataQ <= grantData;
    end
  end

  // Granted master keeps its request up and the owner stays put
  grantHoldA: assert property (@(posedge clk) disable iff (!rstN)
    (busyQ && !memRsp.ready) |=> (busyQ && memReq.valid && grantData == $past(grantData)))
    else $error("bus grant changed during an open transfer");

endmodule

//--- verilog/dataCache.sv
// Direct-mapped write-through data cache, no write allocate; every write waits for the bus
`timescale 1ns/100ps

module dataCache (
  input  logic                clk,
  input  logic                rstN,
  input  memSysPkg::cacheCtlS cacheCtl,
  input  memSysPkg::coreReqS  dataReq,
  output memSysPkg::coreRspS  dataRsp,
  output memSysPkg::busReqS   busReq,
  input  memSysPkg::busRspS   busRsp
);

  logic [memSysPkg::CACHE_LINES-1:0] validQ;
  logic [23:0]                       tagQ  [memSysPkg::CACHE_LINES];
  logic [31:0]                       dataQ [memSysPkg::CACHE_LINES];

  logic [5:0] idx;
  logic       tagMatch;
  logic       hit;
  logic       fill;
  logic       writeHit;

  assign idx      = dataReq.addr.f.index;
  assign tagMatch = validQ[idx] && tagQ[idx] == dataReq.addr.f.tag;
  assign hit      = cacheCtl.dEnable && tagMatch;

  // Read miss refill in an enabled cache only
  assign fill = dataReq.read && !hit && busRsp.ready && cacheCtl.dEnable;
  // Writes keep a matching line current even while disabled
  assign writeHit = dataReq.write && tagMatch && busRsp.ready;

  always_comb
  begin
    busReq.valid    = (dataReq.read && !hit) || dataReq.write;
    busReq.write    = dataReq.write;
    busReq.addr     = dataReq.addr;
    busReq.wdata    = dataReq.wdata;
    // Reads always fetch the full word
    busReq.byteMask = dataReq.write ? dataReq.byteMask : 4'hF;
    dataRsp.stall   = busReq.valid && !busRsp.ready;
    dataRsp.rdata   = hit ? dataQ[idx] : busRsp.rdata;
  end

  // Valid bits
  always_ff @(posedge clk)
  begin
    if (!rstN)
      validQ <= '0;
    else if (cacheCtl.invD)
      validQ <= '0;
    else if (fill)
      validQ[idx] <= 1'b1;
  end

  // Refill or byte merge on a write hit
  always_ff @(posedge clk)
  begin
    if (fill)
    begin
      tagQ[idx]  <= dataReq.addr.f.tag;
      dataQ[idx] <= busRsp.rdata;
    end
    else if (writeHit)
      dataQ[idx] <= memSysPkg::mergeBytes(dataQ[idx], dataReq.wdata, dataReq.byteMask);
  end

  // Memory stage never reads and writes at once
  rwExclusiveA: assert property (@(posedge clk) disable iff (!rstN)
    !(dataReq.read && dataReq.write))
    else $error("data read and write raised together");

  // Request held by the core until the bus completes it
  busStableA: assert property (@(posedge clk) disable iff (!rstN)
    (busReq.valid && !busRsp.ready) |=> $stable(busReq))
    else $error("data bus request changed before ready");

endmodule

//--- verilog/instrCache.sv
// Direct-mapped fetch cache, one word per line; does not snoop data writes
`timescale 1ns/100ps

module instrCache (
  input  logic                clk,
  input  logic                rstN,
  input  memSysPkg::cacheCtlS cacheCtl,
  input  memSysPkg::coreReqS  fetchReq,
  output memSysPkg::coreRspS  fetchRsp,
  output memSysPkg::busReqS   busReq,
  input  memSysPkg::busRspS   busRsp
);

  logic [memSysPkg::CACHE_LINES-1:0] validQ;
  logic [23:0]                       tagQ  [memSysPkg::CACHE_LINES];
  logic [31:0]                       dataQ [memSysPkg::CACHE_LINES];

  logic [5:0] idx;
  logic       hit;
  logic       fill;

  // Lookup
  assign idx  = fetchReq.addr.f.index;
  assign hit  = cacheCtl.iEnable && validQ[idx] && tagQ[idx] == fetchReq.addr.f.tag;
  // Refill only while enabled
  assign fill = busReq.valid && busRsp.ready && cacheCtl.iEnable;

  // Miss goes straight to the bus and is held by the core until ready
  always_comb
  begin
    busReq.valid    = fetchReq.read && !hit;
    busReq.write    = 1'b0;
    busReq.addr     = fetchReq.addr;
    busReq.wdata    = 32'd0;
    busReq.byteMask = 4'hF;
    fetchRsp.stall  = busReq.valid && !busRsp.ready;
    // Bus data forwarded in the ready cycle
    fetchRsp.rdata  = hit ? dataQ[idx] : busRsp.rdata;
  end

  // Invalidate beats a same-cycle fill
  always_ff @(posedge clk)
  begin
    if (!rstN)
      validQ <= '0;
    else if (cacheCtl.invI)
      validQ <= '0;
    else if (fill)
      validQ[idx] <= 1'b1;
  end

  // Tag and word storage
  always_ff @(posedge clk)
  begin
    if (fill)
    begin
      tagQ[idx]  <= fetchReq.addr.f.tag;
      dataQ[idx] <= busRsp.rdata;
    end
  end

  // Fetch stage must hold the address during a miss
  busStableA: assert property (@(posedge clk) disable iff (!rstN)
    (busReq.valid && !busRsp.ready) |=> $stable(busReq))
    else $error("fetch bus request changed before ready");

endmodule

//--- verilog/cacheControl.sv
// Cache control register; invalidate strobes are combinational and need a one-cycle ctlWrite
`timescale 1ns/100ps

module cacheControl (
  input  logic                clk,
  input  logic                rstN,
  input  logic                ctlWrite,
  input  logic [1:0]          ctlAddr,
  input  logic [31:0]         ctlWdata,
  output logic [31:0]         ctlRdata,
  output memSysPkg::cacheCtlS cacheCtl
);

  logic iEnableQ;
  logic dEnableQ;

  // Enable bits cleared by reset
  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      iEnableQ <= 1'b0;
      dEnableQ <= 1'b0;
    end
    else if (ctlWrite && ctlAddr == memSysPkg::CTL_REG)
    begin
      iEnableQ <= ctlWdata[0];
      dEnableQ <= ctlWdata[1];
    end
  end

  // Strobes act on the cache in the write cycle itself
  assign cacheCtl.iEnable = iEnableQ;
  assign cacheCtl.dEnable = dEnableQ;
  assign cacheCtl.invI    = ctlWrite && ctlAddr == memSysPkg::CTL_INV_I;
  assign cacheCtl.invD    = ctlWrite && ctlAddr == memSysPkg::CTL_INV_D;

  // Only the enable register reads back
  assign ctlRdata = (ctlAddr == memSysPkg::CTL_REG) ? {30'd0, dEnableQ, iEnableQ} : 32'd0;

  // Core must drop ctlWrite after one cycle
  invPulseA: assert property (@(posedge clk) disable iff (!rstN)
    (cacheCtl.invI || cacheCtl.invD) |=> !(cacheCtl.invI || cacheCtl.invD))
    else $error("invalidate strobe held longer than one cycle");

endmodule

//--- verilog/memSysPkg.sv
// Shared types for the memory system; one-word lines, 4 KB word memory, fixed wait states
package memSysPkg;

  // Memory and cache geometry
  localparam int MEM_WORDS   = 1024;
  localparam int CACHE_LINES = 64;
  localparam int MEM_WAIT    = 3;
  localparam int WORD_W      = $clog2(MEM_WORDS);
  localparam int WAIT_W      = $clog2(MEM_WAIT + 1);

  // Control register addresses
  localparam logic [1:0] CTL_REG   = 2'd0;
  localparam logic [1:0] CTL_INV_I = 2'd1;
  localparam logic [1:0] CTL_INV_D = 2'd2;

  // Cache view of a byte address with index width matching CACHE_LINES
  typedef struct packed {
    logic [23:0] tag;
    logic [5:0]  index;
    logic [1:0]  offset;
  } addrFieldsS;

  typedef union packed {
    logic [31:0] raw;
    addrFieldsS  f;
  } memAddrU;

  // Core side access
  typedef struct packed {
    memAddrU     addr;
    logic [31:0] wdata;
    logic [3:0]  byteMask;
    logic        read;
    logic        write;
  } coreReqS;

  typedef struct packed {
    logic [31:0] rdata;
    logic        stall;
  } coreRspS;

  // Bus side request held until ready
  typedef struct packed {
    logic        valid;
    logic        write;
    memAddrU     addr;
    logic [31:0] wdata;
    logic [3:0]  byteMask;
  } busReqS;

  typedef struct packed {
    logic [31:0] rdata;
    logic        ready;
  } busRspS;

  typedef struct packed {
    logic iEnable;
    logic dEnable;
    logic invI;
    logic invD;
  } cacheCtlS;

  // Bit n of mask selects byte n
  function automatic logic [31:0] mergeBytes(input logic [31:0] oldWord,
                                             input logic [31:0] newWord,
                                             input logic [3:0]  mask);
    logic [31:0] result;
    result = oldWord;
    for (int b = 0; b < 4; b++)
    begin
      if (mask[b])
        result[8*b +: 8] = newWord[8*b +: 8];
    end
    return result;
  endfunction

endpackage
